//--- run_sim.sh
#!/bin/sh
# compile and run the decode stage testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_instruction_decode \
    -f sources.f \
    -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
    exit 0
else
    exit 1
fi

//--- sources.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/register_bank.sv
verilog/control_unit.sv
verilog/branch_unit.sv
verilog/instruction_decode.sv
verification/tb_instruction_decode.sv

//--- verification/tb_instruction_decode.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module tb_instruction_decode
    import decode_pkg::*;
();

    localparam int NUM_RANDOM  = 400;
    // reset + preload + readback + bypass + random + drain
    localparam int NUM_VECTORS = 10 + `NUM_REGS + `NUM_REGS + 8 + NUM_RANDOM + 4;

    logic                   i_clk;
    logic                   i_reset;
    logic [`DATA_W-1:0]     i_instruction;
    logic [`DATA_W-1:0]     i_pc;
    logic                   i_wb_write_enable;
    logic [`REG_ADDR_W-1:0] i_wb_write_addr;
    logic [`DATA_W-1:0]     i_wb_write_data;
    logic                   i_stall;
    logic                   i_halt;
    ctrl_fields_t           o_ctrl;
    decoded_ops_t           o_ops;
    jump_res_t              o_jump;
    logic                   o_halt;

    logic [`DATA_W-1:0] shadow [`NUM_REGS];    // expected bank contents
    integer             seed;
    int                 n_errors;
    int                 n_checks;
    ctrl_fields_t       exp_ctrl;              // model of the id/ex register
    decoded_ops_t       exp_ops;
    jump_res_t          want_jump;

    instruction_decode i_dut (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_instruction     (i_instruction),
        .i_pc              (i_pc),
        .i_wb_write_enable (i_wb_write_enable),
        .i_wb_write_addr   (i_wb_write_addr),
        .i_wb_write_data   (i_wb_write_data),
        .i_stall           (i_stall),
        .i_halt            (i_halt),
        .o_ctrl            (o_ctrl),
        .o_ops             (o_ops),
        .o_jump            (o_jump),
        .o_halt            (o_halt)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic ctrl_fields_t ref_ctrl(input logic [31:0] word);
        ctrl_fields_t c;
        logic [5:0]   op;
        logic [5:0]   fn;
        op = word[31:26];
        fn = word[5:0];
        c = '0;
        c.wb_mem_to_reg = 1'b1;                 // alu result by default
        if (op == `OP_RTYPE) begin
            c.wb_write_reg = (fn != `FN_JR);
            c.ex_reg_dest  = 1'b1;
            c.ex_alu_op    = (fn == `FN_JALR) ? 2'b00 : 2'b10;
        end else if (op == `OP_JAL) begin
            c.wb_write_reg = 1'b1;
            c.ex_alu_src   = 1'b1;
        end else if (op[5:4] == 2'b10) begin    // load or store
            c.mem_signed = !op[2];
            c.mem_width  = op[1:0];
            c.ex_alu_src = 1'b1;
            if (op[3]) begin
                c.mem_write = 1'b1;
            end else begin
                c.mem_read      = 1'b1;
                c.wb_mem_to_reg = 1'b0;
                c.wb_write_reg  = 1'b1;
            end
        end else if (op[5:3] == 3'b001) begin
            c.wb_write_reg = 1'b1;
            c.ex_alu_src   = 1'b1;
            c.ex_alu_op    = 2'b11;
        end else begin
            c.ex_alu_src = 1'b1;                // branches and the rest
            c.ex_alu_op  = 2'b01;
        end
        return c;
    endfunction

    function automatic decoded_ops_t ref_ops(input logic [31:0] word, input logic [31:0] pc);
        decoded_ops_t d;
        d.opcode = word[31:26];
        d.rs     = word[25:21];
        d.rt     = word[20:16];
        d.rd     = word[15:11];
        d.shamt  = word[10:6];
        d.funct  = word[5:0];
        d.imm    = {{16{word[15]}}, word[15:0]};
        d.ra     = shadow[d.rs];
        d.rb     = shadow[d.rt];
        if (d.opcode == `OP_JAL || (d.opcode == `OP_RTYPE && d.funct == `FN_JALR)) begin
            d.ra = pc;                          // link operands
            d.rb = 32'd4;
            d.rs = '0;
        end
        if (d.opcode == `OP_JAL) begin
            d.rt = 5'd31;
        end
        return d;
    endfunction

    function automatic jump_res_t ref_jump(input logic [31:0] word, input logic [31:0] pc);
        jump_res_t   j;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] offs;
        a    = shadow[word[25:21]];
        b    = shadow[word[20:16]];
        offs = {{14{word[15]}}, word[15:0], 2'b00};    // imm times four
        j = '0;
        if (word[31:26] == `OP_BEQ || word[31:26] == `OP_BNE) begin
            j.reg_in_jump = 2'b01;
            if ((a == b) == (word[31:26] == `OP_BEQ)) begin
                j.jump   = 1'b1;
                j.target = pc + 32'd4 + offs;
            end
        end else if (word[31:26] == `OP_J || word[31:26] == `OP_JAL) begin
            j.jump   = 1'b1;
            j.target = {pc[31:28], word[25:0], 2'b00};
        end else if (word[31:26] == `OP_RTYPE &&
                     (word[5:0] == `FN_JR || word[5:0] == `FN_JALR)) begin
            j.jump        = 1'b1;
            j.target      = a;
            j.reg_in_jump = 2'b10;
        end
        return j;
    endfunction

    function automatic logic [31:0] make_word(input int cls);
        logic [31:0] r;
        logic [31:0] w;
        r = rand32();
        w = rand32();
        case (cls)
            0: w[31:26] = `OP_RTYPE;            // any funct
            1: begin
                w[31:26] = `OP_RTYPE;
                w[5:0]   = `FN_JR;
            end
            2: begin
                w[31:26] = `OP_RTYPE;
                w[5:0]   = `FN_JALR;
            end
            3: w[31:26] = `OP_JAL;
            4: w[31:26] = `OP_J;
            5: w[31:29] = 3'b100;               // load
            6: w[31:29] = 3'b101;               // store
            7: w[31:29] = 3'b001;               // immediate group
            8: begin
                w[31:26] = r[0] ? `OP_BNE : `OP_BEQ;
                if (r[1]) begin
                    w[20:16] = w[25:21];        // force equal operands
                end
            end
            9: w = `INSTR_NOP;
            default: w = `INSTR_HALT;
        endcase
        return w;
    endfunction

    task automatic drive(input logic [31:0] word, input logic [31:0] pc, input logic we,
                         input logic [4:0] waddr, input logic [31:0] wdata,
                         input logic stall, input logic halt);
        @(posedge i_clk);
        i_instruction     <= word;
        i_pc              <= pc;
        i_wb_write_enable <= we;
        i_wb_write_addr   <= waddr;
        i_wb_write_data   <= wdata;
        i_stall           <= stall;
        i_halt            <= halt;
        if (we && waddr != '0) begin
            shadow[waddr] = wdata;              // bypass makes it visible this cycle
        end
    endtask

    // combinational outputs now, id/ex outputs against last cycle's model
    always @(negedge i_clk) begin
        if (i_reset) begin
            exp_ctrl = '0;
            exp_ops  = '0;
        end else begin
            n_checks++;
            want_jump = ref_jump(i_instruction, i_pc);
            if (o_jump !== want_jump) begin
                $display("MISMATCH at %0t: o_jump got %h, expected %h", $time, o_jump, want_jump);
                n_errors++;
            end
            if (o_halt !== (&i_instruction)) begin
                $display("MISMATCH at %0t: o_halt got %b for word %h", $time, o_halt,
                         i_instruction);
                n_errors++;
            end
            if (o_ctrl !== exp_ctrl) begin
                $display("MISMATCH at %0t: o_ctrl got %h, expected %h", $time, o_ctrl, exp_ctrl);
                n_errors++;
            end
            if (o_ops !== exp_ops) begin
                $display("MISMATCH at %0t: o_ops got %h, expected %h", $time, o_ops, exp_ops);
                n_errors++;
            end
            if (!i_halt) begin
                exp_ctrl = (i_stall || i_instruction == `INSTR_NOP) ? '0 :
                           ref_ctrl(i_instruction);
                exp_ops  = ref_ops(i_instruction, i_pc);
            end
        end
    end

    initial begin
        #((NUM_VECTORS + 50) * 4);
        $display("timeout: the run did not finish within %0d ns", (NUM_VECTORS + 50) * 4);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] w;
        logic [4:0]  a;
        int          cls;
        seed              = 32'h9744e044;
        n_errors          = 0;
        n_checks          = 0;
        i_reset           = 1'b1;
        i_instruction     = `INSTR_NOP;
        i_pc              = '0;
        i_wb_write_enable = 1'b0;
        i_wb_write_addr   = '0;
        i_wb_write_data   = '0;
        i_stall           = 1'b0;
        i_halt            = 1'b0;
        for (int k = 0; k < `NUM_REGS; k++) begin
            shadow[k] = '0;
        end
        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;

        // preload every register, r0 included
        for (int k = 0; k < `NUM_REGS; k++) begin
            r = rand32();
            drive(`INSTR_NOP, 32'h0, 1'b1, 5'(k), r, 1'b0, 1'b0);
        end

        // read back through add words
        for (int k = 0; k < `NUM_REGS; k++) begin
            r = rand32();
            w = {`OP_RTYPE, 5'(k), 5'(31 - k), r[15:11], r[10:6], 6'h20};
            drive(w, {r[31:2], 2'b00}, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0);
        end

        // same-cycle write and read, first one on r0
        for (int k = 0; k < 8; k++) begin
            r = rand32();
            a = (k == 0) ? 5'd0 : r[4:0];
            w = {`OP_RTYPE, a, a, 5'd3, 5'd0, 6'h21};
            drive(w, 32'h100, 1'b1, a, rand32(), 1'b0, 1'b0);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            r   = rand32();
            cls = int'(r % 32'd11);
            w   = make_word(cls);
            drive(w, {rand32() & 32'hffff_fffc}, r[14], r[19:15], rand32(),
                  r[10:8] == 3'd0, r[13:11] == 3'd0);
        end

        drive(`INSTR_NOP, 32'h0, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0);
        drive(`INSTR_NOP, 32'h0, 1'b0, 5'd0, 32'h0, 1'b0, 1'b0);
        @(posedge i_clk);
        @(posedge i_clk);

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- verilog/branch_unit.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module branch_unit
    import decode_pkg::*;
(
    input  logic [5:0]         i_opcode,
    input  logic [5:0]         i_funct,
    input  logic [25:0]        i_jump_index,
    input  logic [`DATA_W-1:0] i_imm,
    input  logic [`DATA_W-1:0] i_pc,
    input  logic [`DATA_W-1:0] i_ra,
    input  logic [`DATA_W-1:0] i_rb,
    output jump_res_t          o_jump
);

    logic [`DATA_W-1:0] branch_target;
    logic [`DATA_W-1:0] index_target;
    logic               regs_equal;

    assign branch_target = i_pc + `DATA_W'(4) + (i_imm << 2);   // word offset
    assign index_target  = {i_pc[31:28], i_jump_index, 2'b00};
    assign regs_equal    = (i_ra == i_rb);

    always_comb begin
        o_jump = '0;

        case (i_opcode)
            `OP_BEQ, `OP_BNE: begin
                o_jump.reg_in_jump = 2'b01;
                // bne takes the branch on the opposite compare
                if (regs_equal ^ (i_opcode == `OP_BNE)) begin
                    o_jump.jump   = 1'b1;
                    o_jump.target = branch_target;
                end
            end
            `OP_J, `OP_JAL: begin
                o_jump.jump   = 1'b1;
                o_jump.target = index_target;
            end
            `OP_RTYPE: begin
                if (i_funct == `FN_JR || i_funct == `FN_JALR) begin
                    o_jump.jump        = 1'b1;
                    o_jump.target      = i_ra;
                    o_jump.reg_in_jump = 2'b10;   // rs only
                end
            end
            default: o_jump = '0;
        endcase
    end

endmodule

//--- verilog/control_unit.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module control_unit
    import decode_pkg::*;
(
    input  logic [5:0]   i_opcode,
    input  logic [5:0]   i_funct,
    output ctrl_fields_t o_ctrl
);

    logic is_rtype;
    logic is_jr;
    logic is_jalr;
    logic is_jal;
    logic is_load;
    logic is_store;
    logic is_imm;

    assign is_rtype = (i_opcode == `OP_RTYPE);
    assign is_jr    = is_rtype && (i_funct == `FN_JR);
    assign is_jalr  = is_rtype && (i_funct == `FN_JALR);
    assign is_jal   = (i_opcode == `OP_JAL);
    assign is_load  = (i_opcode[5:3] == 3'b100);
    assign is_store = (i_opcode[5:3] == 3'b101);
    assign is_imm   = (i_opcode[5:3] == 3'b001);

    always_comb begin
        o_ctrl = '0;
        o_ctrl.wb_mem_to_reg = 1'b1;    // alu result unless a load

        if (is_rtype) begin
            o_ctrl.wb_write_reg = !is_jr;
            o_ctrl.ex_reg_dest  = 1'b1;
            o_ctrl.ex_alu_src   = 1'b0;
            // jalr computes pc + 4 in the alu
            o_ctrl.ex_alu_op    = is_jalr ? 2'b00 : 2'b10;
        end else if (is_jal) begin
            o_ctrl.wb_write_reg = 1'b1;
            o_ctrl.ex_alu_src   = 1'b1;
            o_ctrl.ex_alu_op    = 2'b00;
        end else if (is_load) begin
            o_ctrl.wb_mem_to_reg = 1'b0;    // memory data to reg
            o_ctrl.wb_write_reg  = 1'b1;
            o_ctrl.mem_read      = 1'b1;
            o_ctrl.mem_signed    = ~i_opcode[2];
            o_ctrl.mem_width     = i_opcode[1:0];
            o_ctrl.ex_alu_src    = 1'b1;
            o_ctrl.ex_alu_op     = 2'b00;   // address add
        end else if (is_store) begin
            o_ctrl.mem_write     = 1'b1;
            o_ctrl.mem_signed    = ~i_opcode[2];
            o_ctrl.mem_width     = i_opcode[1:0];
            o_ctrl.ex_alu_src    = 1'b1;
            o_ctrl.ex_alu_op     = 2'b00;
        end else if (is_imm) begin
            o_ctrl.wb_write_reg  = 1'b1;
            o_ctrl.ex_alu_src    = 1'b1;
            o_ctrl.ex_alu_op     = 2'b11;   // alu decodes opcode
        end else begin
            // branches and anything unrecognised
            o_ctrl.ex_alu_src    = 1'b1;
            o_ctrl.ex_alu_op     = 2'b01;
        end
    end

endmodule

//--- verilog/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define DATA_W      32
`define REG_ADDR_W  5
`define NUM_REGS    32

// primary opcodes, instruction bits 31:26
`define OP_RTYPE    6'b000000
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101

// funct codes for register jumps
`define FN_JR       6'b001000
`define FN_JALR     6'b001001

`define INSTR_NOP   32'h0000_0000
`define INSTR_HALT  32'hffff_ffff

`define LINK_REG    5'd31       // jal return address register

`endif

//--- verilog/decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

    // control fields for wb, mem and ex stages
    typedef struct packed {
        logic       wb_mem_to_reg;      // 1 alu result, 0 memory data
        logic       wb_write_reg;
        logic       mem_read;
        logic       mem_write;
        logic       mem_signed;
        logic [1:0] mem_width;          // 00 byte, 01 half, 11 word
        logic       ex_reg_dest;        // 1 rd, 0 rt
        logic [1:0] ex_alu_op;          // 00 add, 01 branch, 10 funct, 11 imm
        logic       ex_alu_src;         // 1 immediate
    } ctrl_fields_t;

    // operands and instruction fields handed to execute
    typedef struct packed {
        logic [`DATA_W-1:0]     ra;
        logic [`DATA_W-1:0]     rb;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [5:0]             funct;
        logic [`DATA_W-1:0]     imm;    // sign extended
        logic [5:0]             opcode;
        logic [4:0]             shamt;
    } decoded_ops_t;

    // branch and jump resolution
    typedef struct packed {
        logic               jump;
        logic [`DATA_W-1:0] target;
        logic [1:0]         reg_in_jump;    // 00 none, 01 rs and rt, 10 rs only
    } jump_res_t;

endpackage

//--- verilog/instruction_decode.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module instruction_decode
    import decode_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic [`DATA_W-1:0]     i_instruction,
    input  logic [`DATA_W-1:0]     i_pc,
    input  logic                   i_wb_write_enable,
    input  logic [`REG_ADDR_W-1:0] i_wb_write_addr,
    input  logic [`DATA_W-1:0]     i_wb_write_data,
    input  logic                   i_stall,     // bubble request from hazard unit
    input  logic                   i_halt,      // freeze id/ex
    output ctrl_fields_t           o_ctrl,
    output decoded_ops_t           o_ops,
    output jump_res_t              o_jump,
    output logic                   o_halt
);

    logic [5:0]             opcode;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [4:0]             shamt;
    logic [5:0]             funct;
    logic [25:0]            jump_index;
    logic [`DATA_W-1:0]     imm;
    logic [`DATA_W-1:0]     rd_data_a;
    logic [`DATA_W-1:0]     rd_data_b;
    logic                   is_jal;
    logic                   is_link;
    logic                   bubble;
    ctrl_fields_t           ctrl_next;
    decoded_ops_t           ops_next;

    // instruction fields
    assign opcode     = i_instruction[31:26];
    assign rs         = i_instruction[25:21];
    assign rt         = i_instruction[20:16];
    assign rd         = i_instruction[15:11];
    assign shamt      = i_instruction[10:6];
    assign funct      = i_instruction[5:0];
    assign jump_index = i_instruction[25:0];
    assign imm        = {{(`DATA_W-16){i_instruction[15]}}, i_instruction[15:0]};

    assign is_jal  = (opcode == `OP_JAL);
    assign is_link = is_jal || (opcode == `OP_RTYPE && funct == `FN_JALR);
    assign bubble  = i_stall || (i_instruction == `INSTR_NOP);
    assign o_halt  = (i_instruction == `INSTR_HALT);

    register_bank u_register_bank (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_write_enable (i_wb_write_enable),
        .i_write_addr   (i_wb_write_addr),
        .i_read_addr_a  (rs),
        .i_read_addr_b  (rt),
        .i_write_data   (i_wb_write_data),
        .o_read_data_a  (rd_data_a),
        .o_read_data_b  (rd_data_b)
    );

    control_unit u_control_unit (
        .i_opcode (opcode),
        .i_funct  (funct),
        .o_ctrl   (ctrl_next)
    );

    branch_unit u_branch_unit (
        .i_opcode     (opcode),
        .i_funct      (funct),
        .i_jump_index (jump_index),
        .i_imm        (imm),
        .i_pc         (i_pc),
        .i_ra         (rd_data_a),
        .i_rb         (rd_data_b),
        .o_jump       (o_jump)
    );

    always_comb begin
        ops_next.ra     = rd_data_a;
        ops_next.rb     = rd_data_b;
        ops_next.rs     = rs;
        ops_next.rt     = rt;
        ops_next.rd     = rd;
        ops_next.funct  = funct;
        ops_next.imm    = imm;
        ops_next.opcode = opcode;
        ops_next.shamt  = shamt;

        // link: execute adds pc + 4 to form the return address
        if (is_link) begin
            ops_next.ra = i_pc;
            ops_next.rb = `DATA_W'(4);
            ops_next.rs = '0;
        end
        if (is_jal) begin
            ops_next.rt = `LINK_REG;
        end
    end

    // id/ex pipeline register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ctrl <= '0;
            o_ops  <= '0;
        end else if (!i_halt) begin
            o_ctrl <= bubble ? '0 : ctrl_next;  // bubble keeps operands flowing
            o_ops  <= ops_next;
        end
    end

endmodule

//--- verilog/register_bank.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module register_bank (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_write_enable,
    input  logic [`REG_ADDR_W-1:0] i_write_addr,
    input  logic [`REG_ADDR_W-1:0] i_read_addr_a,
    input  logic [`REG_ADDR_W-1:0] i_read_addr_b,
    input  logic [`DATA_W-1:0]     i_write_data,
    output logic [`DATA_W-1:0]     o_read_data_a,
    output logic [`DATA_W-1:0]     o_read_data_b
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];
    logic               wr_live;    // write that actually lands

    assign wr_live = i_write_enable && (i_write_addr != '0);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_write_addr] <= i_write_data;
        end
    end

    // r0 reads zero, same-cycle write is bypassed
    assign o_read_data_a = (i_read_addr_a == '0) ? '0 :
                           (wr_live && i_write_addr == i_read_addr_a) ? i_write_data :
                           regs[i_read_addr_a];

    assign o_read_data_b = (i_read_addr_b == '0) ? '0 :
                           (wr_live && i_write_addr == i_read_addr_b) ? i_write_data :
                           regs[i_read_addr_b];

endmodule
